// File: hdl/axi_chan_pkg.sv
// AXI4 channel field types and response codes for the split converter subsystem.
// Imported by the read and write converters, the top level and the testbench.
package axi_chan_pkg;

  // Channel field widths.
  localparam int unsigned AxiAddrWidth = 32;
  localparam int unsigned AxiDataWidth = 32;
  localparam int unsigned AxiIdWidth   = 4;
  localparam int unsigned AxiRespWidth = 2;
  localparam int unsigned AxiStrbWidth = AxiDataWidth / 8;

  // Byte address of a transaction.
  typedef logic [AxiAddrWidth-1:0] axi_addr_t;

  // One data beat.
  typedef logic [AxiDataWidth-1:0] axi_data_t;

  // One strobe bit per data byte.
  typedef logic [AxiStrbWidth-1:0] axi_strb_t;

  // Transaction ID, echoed on R and B.
  typedef logic [AxiIdWidth-1:0] axi_id_t;

  // Response code on R and B.
  typedef logic [AxiRespWidth-1:0] axi_resp_t;

  // Normal access.
  localparam axi_resp_t RespOkay   = 2'b00;
  // Slave error, used for addresses outside the memory.
  localparam axi_resp_t RespSlvErr = 2'b10;

  // Writes with every strobe clear never reach a bank.
  localparam bit HideZeroStrb = 1'b1;

endpackage

// File: hdl/mem_pkg.sv
// Geometry of the word-interleaved memory behind the AXI converters.
// Defines the bank, row and word address fields and the bank data types.
package mem_pkg;

  // Four banks, consecutive words go to consecutive banks.
  localparam int unsigned NumBanks  = 4;
  // Words per bank.
  localparam int unsigned BankDepth = 256;

  // Byte address fields: [1:0] byte, [3:2] bank, [11:4] row.
  localparam int unsigned ByteOffBits = 2;
  localparam int unsigned BankBits    = $clog2(NumBanks);
  localparam int unsigned RowBits     = $clog2(BankDepth);
  localparam int unsigned WordBits    = RowBits + BankBits;

  // Total size in bytes, everything at or above is out of range.
  localparam int unsigned MemBytes = NumBanks * BankDepth * 4;

  // Bank select.
  typedef logic [BankBits-1:0] bank_idx_t;

  // Row inside one bank.
  typedef logic [RowBits-1:0] row_t;

  // Word address as {row, bank}.
  typedef logic [WordBits-1:0] word_addr_t;

  // Bank data and byte enables.
  typedef logic [31:0] mem_data_t;
  typedef logic [3:0]  mem_strb_t;

endpackage

// File: hdl/mem_req_if.sv
// One memory request port with grant and a response for every request.
// Converters use master, the arbiter answers on arbiter, banks sit on bank.
interface mem_req_if import mem_pkg::*; ();

  // Request side, held until gnt is seen at a rising edge.
  logic       req;
  word_addr_t addr;
  logic       we;
  mem_data_t  wdata;
  mem_strb_t  strb;

  // Responder side.
  logic       gnt;
  logic       rvalid;
  mem_data_t  rdata;

  // Requester, a converter or the arbiter toward a bank.
  modport master (output req, addr, we, wdata, strb, input gnt, rvalid, rdata);

  // Responder as seen by a converter.
  modport arbiter (input req, addr, we, wdata, strb, output gnt, rvalid, rdata);

  // SRAM bank, always ready so no gnt.
  modport bank (input req, addr, we, wdata, strb, output rvalid, rdata);

endinterface

// File: hdl/axi_read_to_mem.sv
// Turns single-beat AXI reads into one memory read each and returns the R beat.
// One transaction in flight; out-of-range reads answer SLVERR without touching memory.
module axi_read_to_mem import axi_chan_pkg::*; import mem_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      ar_valid_i,
  output logic      ar_ready_o,
  input  axi_id_t   ar_id_i,
  input  axi_addr_t ar_addr_i,
  output logic      r_valid_o,
  input  logic      r_ready_i,
  output axi_id_t   r_id_o,
  output axi_data_t r_data_o,
  output axi_resp_t r_resp_o,
  output logic      busy_o,
  mem_req_if.master mem
);

  typedef enum logic [1:0] {
    RdIdle,
    RdRequest,
    RdWait,
    RdRespond
  } rd_state_e;

  rd_state_e  state_q, state_d;
  axi_id_t    id_q;
  word_addr_t addr_q;
  axi_data_t  data_q;
  axi_resp_t  resp_q;
  logic       in_range;

  // Upper address bits count too, so a plain compare is enough.
  assign in_range = (ar_addr_i < MemBytes);

  always_comb begin
    state_d = state_q;
    case (state_q)
      RdIdle: begin
        if (ar_valid_i) begin
          state_d = in_range ? RdRequest : RdRespond;
        end
      end
      RdRequest: begin
        if (mem.gnt) begin
          state_d = RdWait;
        end
      end
      RdWait: begin
        if (mem.rvalid) begin
          state_d = RdRespond;
        end
      end
      RdRespond: begin
        if (r_ready_i) begin
          state_d = RdIdle;
        end
      end
      default: state_d = RdIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= RdIdle;
    end else begin
      state_q <= state_d;
    end
  end

  // Beat payload.
  always_ff @(posedge clk_i) begin
    if (state_q == RdIdle && ar_valid_i) begin
      id_q   <= ar_id_i;
      addr_q <= ar_addr_i[ByteOffBits +: WordBits];
      // SLVERR beats carry zero data.
      data_q <= '0;
      resp_q <= in_range ? RespOkay : RespSlvErr;
    end else if (state_q == RdWait && mem.rvalid) begin
      data_q <= mem.rdata;
    end
  end

  // AR is taken only when nothing is in flight.
  assign ar_ready_o = (state_q == RdIdle);
  assign r_valid_o  = (state_q == RdRespond);
  assign r_id_o     = id_q;
  assign r_data_o   = data_q;
  assign r_resp_o   = resp_q;
  assign busy_o     = (state_q != RdIdle);

  // Read-only port.
  assign mem.req   = (state_q == RdRequest);
  assign mem.addr  = addr_q;
  assign mem.we    = 1'b0;
  assign mem.wdata = '0;
  assign mem.strb  = '0;

  // A response only ever comes back for the one granted read.
  a_rvalid_in_wait : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem.rvalid |-> state_q == RdWait);

endmodule

// File: hdl/axi_write_to_mem.sv
// Joins AW and W of a single-beat AXI write, issues one masked memory write and answers on B.
// AW and W may come in either order; each is held until its B beat is taken.
module axi_write_to_mem import axi_chan_pkg::*; import mem_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      aw_valid_i,
  output logic      aw_ready_o,
  input  axi_id_t   aw_id_i,
  input  axi_addr_t aw_addr_i,
  input  logic      w_valid_i,
  output logic      w_ready_o,
  input  axi_data_t w_data_i,
  input  axi_strb_t w_strb_i,
  output logic      b_valid_o,
  input  logic      b_ready_i,
  output axi_id_t   b_id_o,
  output axi_resp_t b_resp_o,
  output logic      busy_o,
  mem_req_if.master mem
);

  typedef enum logic [1:0] {
    WrIdle,
    WrRequest,
    WrWait,
    WrRespond
  } wr_state_e;

  wr_state_e  state_q, state_d;
  logic       aw_held_q, w_held_q;
  logic       aw_take, w_take, b_take;
  axi_id_t    id_q;
  word_addr_t addr_q;
  logic       oor_q;
  axi_data_t  data_q;
  axi_strb_t  strb_q;
  logic       skip_mem;

  assign aw_take = aw_valid_i && aw_ready_o;
  assign w_take  = w_valid_i && w_ready_o;
  assign b_take  = b_valid_o && b_ready_i;

  // Out of range, or nothing to write.
  assign skip_mem = oor_q || (HideZeroStrb && strb_q == '0);

  // Holding flags, set on the handshake and freed by the B handshake.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      aw_held_q <= 1'b0;
      w_held_q  <= 1'b0;
    end else if (b_take) begin
      aw_held_q <= 1'b0;
      w_held_q  <= 1'b0;
    end else begin
      aw_held_q <= aw_held_q | aw_take;
      w_held_q  <= w_held_q | w_take;
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_take) begin
      id_q   <= aw_id_i;
      addr_q <= aw_addr_i[ByteOffBits +: WordBits];
      oor_q  <= (aw_addr_i >= MemBytes);
    end
    if (w_take) begin
      data_q <= w_data_i;
      strb_q <= w_strb_i;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      WrIdle: begin
        // Start once both halves are held.
        if (aw_held_q && w_held_q) begin
          state_d = skip_mem ? WrRespond : WrRequest;
        end
      end
      WrRequest: begin
        if (mem.gnt) begin
          state_d = WrWait;
        end
      end
      WrWait: begin
        // The bank acknowledges writes too.
        if (mem.rvalid) begin
          state_d = WrRespond;
        end
      end
      WrRespond: begin
        if (b_ready_i) begin
          state_d = WrIdle;
        end
      end
      default: state_d = WrIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= WrIdle;
    end else begin
      state_q <= state_d;
    end
  end

  assign aw_ready_o = !aw_held_q;
  assign w_ready_o  = !w_held_q;
  assign b_valid_o  = (state_q == WrRespond);
  assign b_id_o     = id_q;
  assign b_resp_o   = oor_q ? RespSlvErr : RespOkay;
  // A held channel is a transaction in progress.
  assign busy_o     = aw_held_q | w_held_q;

  assign mem.req   = (state_q == WrRequest);
  assign mem.addr  = addr_q;
  assign mem.we    = 1'b1;
  assign mem.wdata = data_q;
  assign mem.strb  = strb_q;

  // A waiting request keeps its payload until the arbiter grants it.
  a_payload_stable : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem.req && !mem.gnt |=> mem.req && $stable({mem.addr, mem.we, mem.wdata, mem.strb}));

endmodule

// File: hdl/bank_arbiter.sv
// Per-bank round-robin arbiter between the read and the write converter.
// Grants are combinational; a registered owner per bank steers the response back.
module bank_arbiter import mem_pkg::*; (
  input  logic       clk_i,
  input  logic       arst_n_i,
  mem_req_if.arbiter rd_port,
  mem_req_if.arbiter wr_port,
  mem_req_if.master  banks [NumBanks]
);

  bank_idx_t rd_bank, wr_bank;
  logic [NumBanks-1:0] rd_hit, wr_hit;
  logic [NumBanks-1:0] rd_gnt, wr_gnt;
  // Set when the write port wins the next tie.
  logic [NumBanks-1:0] prio_wr_q;
  // Set when the bank's pending response belongs to the write port.
  logic [NumBanks-1:0] owner_wr_q;
  logic [NumBanks-1:0] rsp_rd, rsp_wr;
  mem_data_t rd_data [NumBanks];
  mem_data_t wr_data [NumBanks];

  // Low word address bits pick the bank.
  assign rd_bank = rd_port.addr[BankBits-1:0];
  assign wr_bank = wr_port.addr[BankBits-1:0];

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    assign rd_hit[b] = rd_port.req && (rd_bank == bank_idx_t'(b));
    assign wr_hit[b] = wr_port.req && (wr_bank == bank_idx_t'(b));

    // Tie goes to the port the flag points at.
    assign wr_gnt[b] = banks[b].gnt && wr_hit[b] && (!rd_hit[b] || prio_wr_q[b]);
    assign rd_gnt[b] = banks[b].gnt && rd_hit[b] && (!wr_hit[b] || !prio_wr_q[b]);

    assign banks[b].req   = rd_gnt[b] | wr_gnt[b];
    assign banks[b].addr  = wr_gnt[b] ? wr_port.addr  : rd_port.addr;
    assign banks[b].we    = wr_gnt[b] ? wr_port.we    : rd_port.we;
    assign banks[b].wdata = wr_gnt[b] ? wr_port.wdata : rd_port.wdata;
    assign banks[b].strb  = wr_gnt[b] ? wr_port.strb  : rd_port.strb;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        prio_wr_q[b]  <= 1'b0;
        owner_wr_q[b] <= 1'b0;
      end else begin
        // Flip only after a real conflict.
        prio_wr_q[b] <= prio_wr_q[b] ^ (rd_hit[b] & wr_hit[b]);
        if (banks[b].req) begin
          owner_wr_q[b] <= wr_gnt[b];
        end
      end
    end

    // Response one cycle later, routed by the owner.
    assign rsp_rd[b]  = banks[b].rvalid && !owner_wr_q[b];
    assign rsp_wr[b]  = banks[b].rvalid && owner_wr_q[b];
    assign rd_data[b] = rsp_rd[b] ? banks[b].rdata : '0;
    assign wr_data[b] = rsp_wr[b] ? banks[b].rdata : '0;

    // The loser of a conflict wins the next conflict on the same bank.
    a_loser_wins_next : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      rd_hit[b] && wr_hit[b] |=> !(rd_hit[b] && wr_hit[b]) || (wr_gnt[b] == $past(rd_gnt[b])));
  end

  assign rd_port.gnt    = |rd_gnt;
  assign wr_port.gnt    = |wr_gnt;
  assign rd_port.rvalid = |rsp_rd;
  assign wr_port.rvalid = |rsp_wr;

  // At most one bank answers each port, so an OR merges the data.
  always_comb begin
    rd_port.rdata = '0;
    wr_port.rdata = '0;
    for (int i = 0; i < NumBanks; i++) begin
      rd_port.rdata = rd_port.rdata | rd_data[i];
      wr_port.rdata = wr_port.rdata | wr_data[i];
    end
  end

  // Bank responses never collide on one port.
  a_one_rsp_per_port : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(rsp_rd) && $onehot0(rsp_wr));

endmodule

// File: hdl/sram_bank.sv
// Single-port word SRAM bank with byte enables and a one-cycle response.
// Answers every request, reads with the stored word and writes with zero data.
module sram_bank import mem_pkg::*; (
  input  logic    clk_i,
  input  logic    arst_n_i,
  mem_req_if.bank port
);

  mem_data_t mem_q [BankDepth];
  mem_data_t rdata_q;
  logic      rvalid_q;
  row_t      row;

  // Bank bits are already decoded, only the row matters here.
  assign row = port.addr[BankBits +: RowBits];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= port.req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (port.req) begin
      if (port.we) begin
        // Only strobed bytes change.
        for (int i = 0; i < 4; i++) begin
          if (port.strb[i]) begin
            mem_q[row][8*i +: 8] <= port.wdata[8*i +: 8];
          end
        end
        rdata_q <= '0;
      end else begin
        rdata_q <= mem_q[row];
      end
    end
  end

  assign port.rvalid = rvalid_q;
  assign port.rdata  = rdata_q;

endmodule

// File: hdl/axi_to_mem_split_top.sv
// AXI4 slave with separate read and write converters in front of four SRAM banks.
// Plain AXI channel ports; busy_o is high while either converter holds a transaction.
module axi_to_mem_split_top import axi_chan_pkg::*; import mem_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  output logic      busy_o,
  // Read address.
  input  logic      ar_valid_i,
  output logic      ar_ready_o,
  input  axi_id_t   ar_id_i,
  input  axi_addr_t ar_addr_i,
  // Read data.
  output logic      r_valid_o,
  input  logic      r_ready_i,
  output axi_id_t   r_id_o,
  output axi_data_t r_data_o,
  output axi_resp_t r_resp_o,
  // Write address.
  input  logic      aw_valid_i,
  output logic      aw_ready_o,
  input  axi_id_t   aw_id_i,
  input  axi_addr_t aw_addr_i,
  // Write data.
  input  logic      w_valid_i,
  output logic      w_ready_o,
  input  axi_data_t w_data_i,
  input  axi_strb_t w_strb_i,
  // Write response.
  output logic      b_valid_o,
  input  logic      b_ready_i,
  output axi_id_t   b_id_o,
  output axi_resp_t b_resp_o
);

  logic read_busy, write_busy;

  // Converter side.
  mem_req_if rd_if ();
  mem_req_if wr_if ();
  // Bank side.
  mem_req_if bank_if [NumBanks] ();

  axi_read_to_mem u_read (
    .clk_i,
    .arst_n_i,
    .ar_valid_i,
    .ar_ready_o,
    .ar_id_i,
    .ar_addr_i,
    .r_valid_o,
    .r_ready_i,
    .r_id_o,
    .r_data_o,
    .r_resp_o,
    .busy_o (read_busy),
    .mem    (rd_if)
  );

  axi_write_to_mem u_write (
    .clk_i,
    .arst_n_i,
    .aw_valid_i,
    .aw_ready_o,
    .aw_id_i,
    .aw_addr_i,
    .w_valid_i,
    .w_ready_o,
    .w_data_i,
    .w_strb_i,
    .b_valid_o,
    .b_ready_i,
    .b_id_o,
    .b_resp_o,
    .busy_o (write_busy),
    .mem    (wr_if)
  );

  bank_arbiter u_arb (
    .clk_i,
    .arst_n_i,
    .rd_port (rd_if),
    .wr_port (wr_if),
    .banks   (bank_if)
  );

  for (genvar g = 0; g < NumBanks; g++) begin : gen_bank
    // Banks take every request.
    assign bank_if[g].gnt = 1'b1;

    sram_bank u_bank (
      .clk_i,
      .arst_n_i,
      .port (bank_if[g])
    );
  end

  assign busy_o = read_busy | write_busy;

endmodule

// File: test/tb_axi_to_mem_split.sv
// Self-checking testbench for the split AXI to memory subsystem.
// Drives directed and random single-beat traffic and checks every R and B beat
// against a shadow memory. Prints the result line at the end of the run.
module tb_axi_to_mem_split import axi_chan_pkg::*; import mem_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned HalfPeriod  = 20;
  localparam int unsigned ResetCycles = 5;
  // About 400 transactions at no more than 40 cycles each.
  localparam int unsigned MaxCycles   = 20000;
  localparam int unsigned RandOps     = 300;
  localparam int unsigned HalfOps     = RandOps / 2;
  // First byte address past the 4 KiB memory.
  localparam axi_addr_t   MemLimit    = 32'h0000_1000;
  // Random reads use the upper half, random writes the lower half.
  localparam axi_addr_t   ReadBase    = 32'h0000_0800;
  localparam int unsigned ReadWords   = 32;
  localparam axi_strb_t   PartialStrb [4] = '{4'b0001, 4'b0110, 4'b1000, 4'b0101};

  logic      clk_i = 1'b0;
  logic      arst_n_i;
  logic      busy_o;
  logic      ar_valid_i;
  logic      ar_ready_o;
  axi_id_t   ar_id_i;
  axi_addr_t ar_addr_i;
  logic      r_valid_o;
  logic      r_ready_i;
  axi_id_t   r_id_o;
  axi_data_t r_data_o;
  axi_resp_t r_resp_o;
  logic      aw_valid_i;
  logic      aw_ready_o;
  axi_id_t   aw_id_i;
  axi_addr_t aw_addr_i;
  logic      w_valid_i;
  logic      w_ready_o;
  axi_data_t w_data_i;
  axi_strb_t w_strb_i;
  logic      b_valid_o;
  logic      b_ready_i;
  axi_id_t   b_id_o;
  axi_resp_t b_resp_o;

  integer      seed;
  int unsigned cycles = 0;
  logic        rand_ready = 1'b0;
  logic [255:0] r_ready_pat;
  logic [255:0] b_ready_pat;
  // Raw random words for the concurrent phase.
  logic [31:0] rd_rand [HalfOps];
  logic [31:0] wr_rand [HalfOps];
  axi_data_t   wr_data [HalfOps];

  // Expected memory contents, one word per word address.
  axi_data_t shadow [1024];

  // Expected R beats, queued at the AR handshake.
  axi_data_t r_data_q [$];
  axi_resp_t r_resp_q [$];
  axi_id_t   r_id_q [$];
  // Write halves, joined at the B handshake.
  axi_addr_t aw_addr_q [$];
  axi_id_t   aw_id_q [$];
  axi_data_t w_data_q [$];
  axi_strb_t w_strb_q [$];
  // In-range words written in the random phase.
  axi_addr_t written_q [$];
  // Address handshakes still waiting for their response.
  int unsigned rd_open = 0;
  int unsigned wr_open = 0;

  axi_to_mem_split_top u_dut (.*);

  always #(HalfPeriod) clk_i = ~clk_i;

  // Expected read result for a byte address.
  function automatic axi_data_t exp_read(input axi_addr_t addr, output axi_resp_t resp);
    if (addr >= MemLimit) begin
      resp = RespSlvErr;
      return '0;
    end
    resp = RespOkay;
    return shadow[addr[11:2]];
  endfunction

  // Merges strobed bytes into the shadow, out-of-range writes change nothing.
  function automatic void apply_write(input axi_addr_t addr, input axi_data_t data,
                                      input axi_strb_t strb);
    if (addr < MemLimit) begin
      for (int i = 0; i < 4; i++) begin
        if (strb[i]) begin
          shadow[addr[11:2]][8*i +: 8] = data[8*i +: 8];
        end
      end
    end
  endfunction

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display(">>> FAIL");
    $fatal(1, "Run stopped at the first error.");
  endtask

  task automatic check_data(input string sig, input axi_data_t exp, input axi_data_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("Error at %0t ns: %s expected %h, actual %h",
                              $time, sig, exp, act));
    end
  endtask

  task automatic check_resp(input string sig, input axi_resp_t exp, input axi_resp_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("Error at %0t ns: %s expected %h, actual %h",
                              $time, sig, exp, act));
    end
  endtask

  task automatic check_id(input string sig, input axi_id_t exp, input axi_id_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("Error at %0t ns: %s expected %h, actual %h",
                              $time, sig, exp, act));
    end
  endtask

  // Ready is sampled just after the falling edge, the handshake lands on the next rising edge.
  task automatic send_ar(input axi_addr_t addr, input axi_id_t id);
    @(negedge clk_i);
    ar_valid_i = 1'b1;
    ar_addr_i  = addr;
    ar_id_i    = id;
    #1;
    while (!ar_ready_o) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    ar_valid_i = 1'b0;
  endtask

  task automatic send_aw(input axi_addr_t addr, input axi_id_t id);
    @(negedge clk_i);
    aw_valid_i = 1'b1;
    aw_addr_i  = addr;
    aw_id_i    = id;
    #1;
    while (!aw_ready_o) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    aw_valid_i = 1'b0;
  endtask

  task automatic send_w(input axi_data_t data, input axi_strb_t strb);
    @(negedge clk_i);
    w_valid_i = 1'b1;
    w_data_i  = data;
    w_strb_i  = strb;
    #1;
    while (!w_ready_o) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    w_valid_i = 1'b0;
  endtask

  // The two delays set the order of AW and W.
  task automatic do_write(input axi_addr_t addr, input axi_id_t id, input axi_data_t data,
                          input axi_strb_t strb, input int unsigned aw_dly,
                          input int unsigned w_dly);
    fork
      begin
        repeat (aw_dly) @(negedge clk_i);
        send_aw(addr, id);
      end
      begin
        repeat (w_dly) @(negedge clk_i);
        send_w(data, strb);
      end
    join
  endtask

  task automatic wait_idle();
    while (rd_open != 0 || wr_open != 0) begin
      @(posedge clk_i);
    end
    @(negedge clk_i);
  endtask

  // Run limit.
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MaxCycles) begin
      $display("Timeout: the test did not finish within %0d cycles.", MaxCycles);
      $display(">>> FAIL");
      $fatal(1, "Run stopped by the cycle limit.");
    end
  end

  // Back-pressure on R and B, random only in the concurrent phase.
  initial begin : ready_driver
    r_ready_i = 1'b1;
    b_ready_i = 1'b1;
    forever begin
      @(negedge clk_i);
      r_ready_i = !rand_ready || r_ready_pat[cycles[7:0]];
      b_ready_i = !rand_ready || b_ready_pat[cycles[7:0]];
    end
  end

  // Watches every handshake just before the rising edge where it happens.
  always begin : monitor
    axi_addr_t addr;
    axi_data_t exp_data;
    axi_resp_t exp_resp;
    @(negedge clk_i);
    #1;
    if ((rd_open != 0 || wr_open != 0) && busy_o !== 1'b1) begin
      stop_on_error("busy_o was low while a transaction was still open.");
    end
    if (r_valid_o && r_ready_i) begin
      if (r_id_q.size() == 0) begin
        stop_on_error("An R beat arrived with no read outstanding.");
      end else begin
        check_id("r_id_o", r_id_q.pop_front(), r_id_o);
        check_data("r_data_o", r_data_q.pop_front(), r_data_o);
        check_resp("r_resp_o", r_resp_q.pop_front(), r_resp_o);
        rd_open--;
      end
    end
    if (b_valid_o && b_ready_i) begin
      if (aw_addr_q.size() == 0 || w_data_q.size() == 0) begin
        stop_on_error("A B beat arrived with no write outstanding.");
      end else begin
        addr     = aw_addr_q.pop_front();
        exp_resp = (addr >= MemLimit) ? RespSlvErr : RespOkay;
        check_id("b_id_o", aw_id_q.pop_front(), b_id_o);
        check_resp("b_resp_o", exp_resp, b_resp_o);
        // Memory is written before B, so the shadow follows here.
        apply_write(addr, w_data_q.pop_front(), w_strb_q.pop_front());
        wr_open--;
      end
    end
    if (ar_valid_i && ar_ready_o) begin
      exp_data = exp_read(ar_addr_i, exp_resp);
      r_data_q.push_back(exp_data);
      r_resp_q.push_back(exp_resp);
      r_id_q.push_back(ar_id_i);
      rd_open++;
    end
    if (aw_valid_i && aw_ready_o) begin
      aw_addr_q.push_back(aw_addr_i);
      aw_id_q.push_back(aw_id_i);
      wr_open++;
    end
    if (w_valid_i && w_ready_o) begin
      w_data_q.push_back(w_data_i);
      w_strb_q.push_back(w_strb_i);
    end
  end

  initial begin : stimulus
    axi_addr_t addr;
    axi_data_t data;
    seed       = 32'hcf59_cc3e;
    arst_n_i   = 1'b0;
    ar_valid_i = 1'b0;
    ar_addr_i  = '0;
    ar_id_i    = '0;
    aw_valid_i = 1'b0;
    aw_addr_i  = '0;
    aw_id_i    = '0;
    w_valid_i  = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    // Ready patterns stall about one cycle in four.
    for (int k = 0; k < 256; k++) begin
      r_ready_pat[k] = (($random(seed) & 3) != 0);
      b_ready_pat[k] = (($random(seed) & 3) != 0);
    end
    for (int k = 0; k < HalfOps; k++) begin
      rd_rand[k] = $random(seed);
      wr_rand[k] = $random(seed);
      wr_data[k] = $random(seed);
    end
    repeat (ResetCycles) @(negedge clk_i);
    arst_n_i = 1'b1;
    #1;
    if (busy_o !== 1'b0) begin
      stop_on_error("busy_o was high right after reset.");
    end

    // Full-strobe write and read back, one word in each bank.
    for (int b = 0; b < NumBanks; b++) begin
      addr = 32'h40 + axi_addr_t'(4 * b);
      data = $random(seed);
      do_write(addr, axi_id_t'(b), data, 4'hf, 0, 0);
      wait_idle();
      send_ar(addr, axi_id_t'(b + 8));
      wait_idle();
    end

    // Partial strobes merge byte by byte, AW and W take turns leading.
    for (int k = 0; k < 4; k++) begin
      data = $random(seed);
      do_write(32'h44, axi_id_t'(k), data, PartialStrb[k], k % 2, (k + 1) % 2);
      wait_idle();
      send_ar(32'h44, axi_id_t'(k + 4));
      wait_idle();
    end

    // No strobes, the word must keep its value.
    do_write(32'h48, 4'h3, 32'hdead_beef, 4'h0, 2, 0);
    wait_idle();
    send_ar(32'h48, 4'h3);
    wait_idle();

    // Out of range, the writes would alias onto 0x40 and 0x44 if they reached a bank.
    send_ar(32'h0000_1000, 4'h5);
    send_ar(32'hffff_fffc, 4'h6);
    send_ar(32'h8000_0040, 4'h7);
    do_write(32'h0000_1040, 4'h8, 32'h0bad_0bad, 4'hf, 0, 0);
    do_write(32'h8000_0044, 4'h9, 32'h0bad_0bad, 4'hf, 0, 1);
    wait_idle();
    send_ar(32'h40, 4'ha);
    send_ar(32'h44, 4'hb);
    wait_idle();

    // Fill the words that the random reads use.
    for (int k = 0; k < ReadWords; k++) begin
      data = $random(seed);
      do_write(ReadBase + axi_addr_t'(4 * k), axi_id_t'(k), data, 4'hf, 0, 0);
    end
    wait_idle();

    // Concurrent traffic in disjoint halves of the same banks.
    rand_ready = 1'b1;
    fork
      begin : rd_branch
        axi_addr_t rd_addr;
        for (int i = 0; i < HalfOps; i++) begin
          repeat (rd_rand[i][10:9]) @(negedge clk_i);
          rd_addr = ReadBase + (axi_addr_t'(rd_rand[i][4:0]) << 2);
          if (rd_rand[i][15:12] == 4'h0) begin
            rd_addr = rd_addr | MemLimit;
          end
          send_ar(rd_addr, axi_id_t'(rd_rand[i][8:5]));
        end
      end
      begin : wr_branch
        axi_addr_t wr_addr;
        for (int i = 0; i < HalfOps; i++) begin
          repeat (wr_rand[i][22:21]) @(negedge clk_i);
          wr_addr = axi_addr_t'(wr_rand[i][8:0]) << 2;
          if (wr_rand[i][27:24] == 4'h0) begin
            wr_addr = wr_addr | MemLimit;
          end else begin
            written_q.push_back(wr_addr);
          end
          do_write(wr_addr, axi_id_t'(wr_rand[i][12:9]), wr_data[i],
                   axi_strb_t'(wr_rand[i][16:13]), int'(wr_rand[i][18:17]),
                   int'(wr_rand[i][20:19]));
        end
      end
    join
    wait_idle();
    rand_ready = 1'b0;

    // Read back everything the random writes touched.
    foreach (written_q[k]) begin
      send_ar(written_q[k], axi_id_t'(k));
    end
    wait_idle();
    @(negedge clk_i);
    #1;
    if (busy_o !== 1'b0) begin
      stop_on_error("busy_o stayed high after all responses had drained.");
    end
    $display(">>> PASS");
    $finish;
  end

endmodule

// File: list.f
hdl/axi_chan_pkg.sv
hdl/mem_pkg.sv
hdl/mem_req_if.sv
hdl/axi_read_to_mem.sv
hdl/axi_write_to_mem.sv
hdl/bank_arbiter.sv
hdl/sram_bank.sv
hdl/axi_to_mem_split_top.sv
test/tb_axi_to_mem_split.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it into sim.log and checks the result.

cd "$(dirname "$0")" || exit 1

TOP=tb_axi_to_mem_split
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module "$TOP" -f list.f -o "$TOP"
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Build failed with status $build_status."
  exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q ">>> FAIL" "$LOG"; then
  echo "Simulation reported a failure."
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status."
  exit 1
fi

echo "Simulation passed."
exit 0
